/* Makefile */
# Verilator build and run of the issue cluster testbench

TOP := issue_cluster_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f issue_cluster.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* bench/issue_cluster_tb.sv */
`timescale 1ns/10ps
`include "issue_settings.svh"

module issue_cluster_tb import issue_pkg::*; ();

  localparam int GOLDEN_DEPTH      = 128;
  localparam int CYCLES_PER_RECORD = 200;
  localparam int ROB_ENTRIES       = 1 << `ROB_IDX_SIZE;

  logic      in_clk;
  logic      in_rst;
  dispatch_t dispatch;
  logic      dispatch_valid;
  logic      full;
  bcast_t    bcast;
  logic      flush;
  result_t   result;
  logic      result_valid;
  logic      result_ready;

  // one 25 digit record per line as laid out in the golden file header
  logic [99:0] golden [GOLDEN_DEPTH];
  int          n_records = 0;

  // expected results indexed by destination
  result_t exp_result [ROB_ENTRIES];
  logic    has_expect [ROB_ENTRIES];
  logic    seen       [ROB_ENTRIES];
  int      e_total    = 0;
  int      seen_count = 0;

  // set once a dispatch had to wait on a full station
  logic dispatch_held = 1'b0;

  logic [31:0] lfsr_state = 32'h92f38634;

  tb_clock u_clock (
    .in_clk (in_clk),
    .in_rst (in_rst)
  );

  issue_cluster dut (
    .in_clk         (in_clk),
    .in_rst         (in_rst),
    .dispatch       (dispatch),
    .dispatch_valid (dispatch_valid),
    .full           (full),
    .bcast          (bcast),
    .flush          (flush),
    .result         (result),
    .result_valid   (result_valid),
    .result_ready   (result_ready)
  );

  // right shifting galois lfsr for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h80200003;
    end
    return next;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_flags(input logic [`ROB_IDX_SIZE-1:0] dst, input nzcv_t got,
                             input nzcv_t want);
    if (got !== want) begin
      abort_run($sformatf("Fail at time %0t: rob index %0d flags nzcv %b, expected %b",
                          $time, dst, got, want));
    end
  endtask

  task automatic check_full(input logic got, input logic want);
    if (got !== want) begin
      abort_run($sformatf("Fail at time %0t: full is %b, expected %b", $time, got, want));
    end
  endtask

  // results are matched by destination in any completion order
  task automatic check_result(input result_t got);
    result_t want;
    want = exp_result[got.dst];
    if (has_expect[got.dst] !== 1'b1) begin
      abort_run($sformatf("Fail at time %0t: result for rob index %0d has no expected record",
                          $time, got.dst));
    end else if (seen[got.dst]) begin
      abort_run($sformatf("Fail at time %0t: result for rob index %0d arrived twice",
                          $time, got.dst));
    end else if (got.value !== want.value) begin
      abort_run($sformatf("Fail at time %0t: rob index %0d value %h, expected %h",
                          $time, got.dst, got.value, want.value));
    end else begin
      seen[got.dst] = 1'b1;
      seen_count++;
      check_flags(got.dst, got.nzcv, want.nzcv);
    end
  endtask

  // reads the file and collects E records up to the all zero end record
  task automatic load_golden();
    logic [3:0]               kind;
    logic [`ROB_IDX_SIZE-1:0] dst;
    logic                     done;
    int                       count;
    $readmemh("bench/issue_golden.txt", golden);
    for (int i = 0; i < ROB_ENTRIES; i++) begin
      has_expect[i] = 1'b0;
    end
    count = 0;
    done  = 1'b0;
    for (int i = 0; i < GOLDEN_DEPTH && !done; i++) begin
      kind = golden[i][99:96];
      if (kind == 4'h0) begin
        done = 1'b1;
      end else begin
        count++;
        if (kind == 4'he) begin
          dst                    = golden[i][11:8];
          exp_result[dst].dst    = dst;
          exp_result[dst].value  = golden[i][83:52];
          exp_result[dst].nzcv   = nzcv_t'(golden[i][3:0]);
          has_expect[dst]        = 1'b1;
          e_total++;
        end else if (kind != 4'hd && kind != 4'hb && kind != 4'hf) begin
          abort_run($sformatf("unknown record kind %h on golden record %0d", kind, i));
        end
      end
    end
    n_records = count;
    if (!done) begin
      abort_run("the golden file has no end record");
    end
  endtask

  task automatic clear_inputs();
    dispatch       = '0;
    dispatch_valid = 1'b0;
    bcast          = '0;
    flush          = 1'b0;
  endtask

  task automatic drive_dispatch(input logic [99:0] rec);
    dispatch.op          = alu_op_e'(rec[94:92]);
    dispatch.a.valid     = rec[88];
    dispatch.a.rob_index = rec[87:84];
    dispatch.a.value     = rec[83:52];
    dispatch.b.valid     = rec[48];
    dispatch.b.rob_index = rec[47:44];
    dispatch.b.value     = rec[43:12];
    dispatch.dst         = rec[11:8];
    dispatch.set_nzcv    = rec[4];
    dispatch.nzcv        = nzcv_t'(rec[3:0]);
    dispatch_valid       = 1'b1;
    // held while full and accepted at the next rising edge once there is room
    while (full) begin
      dispatch_held = 1'b1;
      @(negedge in_clk);
    end
  endtask

  task automatic drive_bcast(input logic [99:0] rec);
    bcast.valid     = 1'b1;
    bcast.rob_index = rec[87:84];
    bcast.value     = rec[83:52];
  endtask

  task automatic wait_for_results(input int count);
    while (seen_count < count) @(negedge in_clk);
  endtask

  // stimulus with one record per cycle on the falling edge
  initial begin
    logic [3:0] kind;
    int         e_passed;
    e_passed = 0;
    clear_inputs();
    load_golden();
    @(negedge in_rst);
    @(negedge in_clk);
    // empty station and pipeline out of reset
    check_full(full, 1'b0);
    if (result_valid !== 1'b0) begin
      abort_run("result_valid is not low after reset");
    end
    for (int i = 0; i < n_records; i++) begin
      kind = golden[i][99:96];
      if (kind == 4'he) begin
        e_passed++;
      end else if (kind == 4'hb && golden[i][92]) begin
        // broadcast shares the cycle of the next dispatch
        drive_bcast(golden[i]);
      end else begin
        if (kind == 4'hd) begin
          drive_dispatch(golden[i]);
        end else if (kind == 4'hb) begin
          drive_bcast(golden[i]);
        end else begin
          // earlier results leave first so only waiting entries get flushed
          wait_for_results(e_passed);
          flush = 1'b1;
        end
        @(negedge in_clk);
        clear_inputs();
      end
    end
    wait_for_results(e_total);
    // quiet window where a flushed entry would show up
    repeat (20) @(negedge in_clk);
    if (!dispatch_held) begin
      abort_run("no dispatch ever waited on a full station");
    end
    // flushed and drained station has room again
    check_full(full, 1'b0);
    $display("All tests passed");
    $finish;
  end

  // random back-pressure and result monitor
  initial begin
    result_ready = 1'b0;
    for (int i = 0; i < ROB_ENTRIES; i++) begin
      seen[i] = 1'b0;
    end
    forever begin
      @(negedge in_clk);
      lfsr_state   = lfsr_next(lfsr_state);
      result_ready = lfsr_state[0];
      // valid and ready both hold until the next rising edge
      if (result_valid === 1'b1 && result_ready) begin
        check_result(result);
      end
    end
  end

  // watchdog scaled by the number of records
  initial begin
    wait (n_records > 0);
    repeat (CYCLES_PER_RECORD * n_records) @(posedge in_clk);
    abort_run("timeout, the DUT did not deliver every expected result in time");
  end

endmodule

/* bench/issue_golden.txt */
// kind op a_valid a_tag a_value b_valid b_tag b_value dst set_nzcv nzcv, one hex digit each, values 8
// D dispatch, B broadcast (op 1 = same cycle as next D), F flush, E expected result, 0 end
// every opcode with ready operands
D_0_1_0_7fffffff_1_0_00000001_0_1_0
D_1_1_0_00000005_1_0_00000005_1_1_0
D_2_1_0_f0f0f0f0_1_0_ff00ff00_2_1_3
D_3_1_0_00ff0000_1_0_0000ff00_3_0_5
D_4_1_0_12345678_1_0_12345678_4_1_8
D_5_1_0_deadbeef_1_0_80000001_5_1_2
E_0_0_0_80000000_0_0_00000000_0_0_9
E_0_0_0_00000000_0_0_00000000_1_0_6
E_0_0_0_f000f000_0_0_00000000_2_0_b
E_0_0_0_00ffff00_0_0_00000000_3_0_5
E_0_0_0_00000000_0_0_00000000_4_0_4
E_0_0_0_80000001_0_0_00000000_5_0_a
// wakeup after the dispatch and in the same cycle
D_0_1_0_00000100_0_3_00000000_6_0_0
B_0_0_3_00000023_0_0_00000000_0_0_0
E_0_0_0_00000123_0_0_00000000_6_0_0
B_1_0_4_00000010_0_0_00000000_0_0_0
D_1_0_4_00000000_1_0_00000020_7_1_0
E_0_0_0_fffffff0_0_0_00000000_7_0_8
// six waiting dispatches fill the station
D_0_0_5_00000000_1_0_ffffffff_8_1_0
D_4_1_0_0000ffff_0_6_00000000_9_0_f
D_1_0_7_00000000_0_8_00000000_a_1_0
D_3_0_b_00000000_1_0_0000000f_b_1_0
B_0_0_5_00000001_0_0_00000000_0_0_0
D_5_1_0_11111111_0_c_00000000_c_0_4
B_0_0_6_ffff0000_0_0_00000000_0_0_0
D_2_0_d_00000000_1_0_0000000f_d_1_1
B_0_0_7_80000000_0_0_00000000_0_0_0
B_0_0_8_00000001_0_0_00000000_0_0_0
B_0_0_b_000000f0_0_0_00000000_0_0_0
B_0_0_c_cafef00d_0_0_00000000_0_0_0
B_0_0_d_00000030_0_0_00000000_0_0_0
E_0_0_0_00000000_0_0_00000000_8_0_6
E_0_0_0_ffffffff_0_0_00000000_9_0_f
E_0_0_0_7fffffff_0_0_00000000_a_0_3
E_0_0_0_000000ff_0_0_00000000_b_0_0
E_0_0_0_cafef00d_0_0_00000000_c_0_4
E_0_0_0_00000000_0_0_00000000_d_0_5
// flushed entry stays silent, later dispatch completes
D_0_0_9_00000000_1_0_00000001_e_1_0
F_0_0_0_00000000_0_0_00000000_0_0_0
B_0_0_9_00000005_0_0_00000000_0_0_0
D_1_1_0_00000064_0_a_00000000_f_0_2
B_0_0_a_00000014_0_0_00000000_0_0_0
E_0_0_0_00000050_0_0_00000000_f_0_2
0_0_0_0_00000000_0_0_00000000_0_0_0

/* bench/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
  output logic in_clk,
  output logic in_rst
);

  // 40 ns period, first rising edge at 20 ns
  initial begin
    in_clk = 1'b0;
    forever #20 in_clk = ~in_clk;
  end

  // reset covers two rising edges and drops on a falling edge
  initial begin
    in_rst = 1'b1;
    repeat (2) @(posedge in_clk);
    @(negedge in_clk);
    in_rst = 1'b0;
  end

endmodule

/* issue_cluster.f */
+incdir+verilog
verilog/issue_pkg.sv
verilog/rs_alloc.sv
verilog/rs_entry.sv
verilog/rs_select.sv
verilog/int_alu.sv
verilog/issue_cluster.sv
bench/tb_clock.sv
bench/issue_cluster_tb.sv

/* verilog/int_alu.sv */
`timescale 1ns/10ps
`include "issue_settings.svh"

module int_alu import issue_pkg::*; (
  input  logic    in_clk,
  input  logic    in_rst,
  input  issue_t  issue,
  input  logic    issue_valid,
  input  logic    flush,
  input  logic    result_ready,
  output logic    fu_ready,
  output result_t result,
  output logic    result_valid
);

  // sign bit position
  localparam int MSB = `GPR_SIZE - 1;

  // adder outputs with carry out on top
  logic [`GPR_SIZE:0]   sum;
  logic [`GPR_SIZE:0]   diff;
  logic [`GPR_SIZE-1:0] value;
  nzcv_t                flags;

  // room for a new item when empty or drained this cycle
  assign fu_ready = !result_valid || result_ready;

  always_comb begin
    sum  = {1'b0, issue.val_a} + {1'b0, issue.val_b};
    // subtract as a + ~b + 1 so carry means no borrow
    diff = {1'b0, issue.val_a} + {1'b0, ~issue.val_b} + {{`GPR_SIZE{1'b0}}, 1'b1};
    case (issue.op)
      ADD:     value = sum[MSB:0];
      SUB:     value = diff[MSB:0];
      AND:     value = issue.val_a & issue.val_b;
      ORR:     value = issue.val_a | issue.val_b;
      EOR:     value = issue.val_a ^ issue.val_b;
      // mov copies operand b
      default: value = issue.val_b;
    endcase
    // incoming flags pass through unless set_nzcv
    flags = issue.nzcv;
    if (issue.set_nzcv) begin
      flags.n = value[MSB];
      flags.z = (value == '0);
      // logical ops and mov keep c and v
      if (issue.op == ADD) begin
        flags.c = sum[`GPR_SIZE];
        flags.v = (issue.val_a[MSB] == issue.val_b[MSB]) && (value[MSB] != issue.val_a[MSB]);
      end else if (issue.op == SUB) begin
        flags.c = diff[`GPR_SIZE];
        flags.v = (issue.val_a[MSB] != issue.val_b[MSB]) && (value[MSB] != issue.val_a[MSB]);
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      result_valid <= 1'b0;
    end else if (flush) begin
      result_valid <= 1'b0;
    end else if (fu_ready) begin
      result_valid <= issue_valid;
    end
  end

  // result payload changes only when a new item is accepted
  always_ff @(posedge in_clk) begin
    if (fu_ready && issue_valid) begin
      result.dst   <= issue.dst;
      result.value <= value;
      result.nzcv  <= flags;
    end
  end

  // an unaccepted result stays put until the consumer takes it
  a_result_stable : assert property (
    @(posedge in_clk) disable iff (in_rst)
    (result_valid && !result_ready && !flush) |=> (result_valid && $stable(result))
  );

endmodule

/* verilog/issue_cluster.sv */
`timescale 1ns/10ps
`include "issue_settings.svh"

module issue_cluster import issue_pkg::*; (
  input  logic      in_clk,
  input  logic      in_rst,
  input  dispatch_t dispatch,
  input  logic      dispatch_valid,
  output logic      full,
  input  bcast_t    bcast,
  input  logic      flush,
  output result_t   result,
  output logic      result_valid,
  input  logic      result_ready
);

  // per entry status
  logic [`RS_SIZE-1:0] busy;
  logic [`RS_SIZE-1:0] ready;
  logic [`RS_SIZE-1:0] write;
  logic [`RS_SIZE-1:0] grant;
  issue_t              entries [`RS_SIZE];

  // issue register to alu
  issue_t issue;
  logic   issue_valid;
  logic   fu_ready;

  rs_alloc u_alloc (
    .in_clk         (in_clk),
    .in_rst         (in_rst),
    .dispatch_valid (dispatch_valid),
    .busy           (busy),
    .write          (write),
    .full           (full)
  );

  // station entries all share dispatch, broadcast and flush
  for (genvar i = 0; i < `RS_SIZE; i++) begin : g_entry
    rs_entry u_entry (
      .in_clk   (in_clk),
      .in_rst   (in_rst),
      .write    (write[i]),
      .dispatch (dispatch),
      .bcast    (bcast),
      .flush    (flush),
      .grant    (grant[i]),
      .busy     (busy[i]),
      .ready    (ready[i]),
      .contents (entries[i])
    );
  end

  rs_select u_select (
    .in_clk      (in_clk),
    .in_rst      (in_rst),
    .ready       (ready),
    .entries     (entries),
    .fu_ready    (fu_ready),
    .flush       (flush),
    .grant       (grant),
    .issue       (issue),
    .issue_valid (issue_valid)
  );

  int_alu u_alu (
    .in_clk       (in_clk),
    .in_rst       (in_rst),
    .issue        (issue),
    .issue_valid  (issue_valid),
    .flush        (flush),
    .result_ready (result_ready),
    .fu_ready     (fu_ready),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

/* verilog/issue_pkg.sv */
`include "issue_settings.svh"

package issue_pkg;

  // condition flags in arm order
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // integer alu operations handled by this cluster
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    ORR = 3'd3,
    EOR = 3'd4,
    MOV = 3'd5
  } alu_op_e;

  // source operand, either a value or the tag it waits on
  typedef struct packed {
    logic                     valid;
    logic [`GPR_SIZE-1:0]     value;
    logic [`ROB_IDX_SIZE-1:0] rob_index;
  } operand_t;

  // one instruction as it arrives from dispatch
  typedef struct packed {
    alu_op_e                  op;
    operand_t                 a;
    operand_t                 b;
    logic [`ROB_IDX_SIZE-1:0] dst;
    logic                     set_nzcv;
    nzcv_t                    nzcv;
  } dispatch_t;

  // result broadcast seen by every station entry
  typedef struct packed {
    logic                     valid;
    logic [`ROB_IDX_SIZE-1:0] rob_index;
    logic [`GPR_SIZE-1:0]     value;
  } bcast_t;

  // fully resolved instruction handed to the alu
  typedef struct packed {
    alu_op_e                  op;
    logic [`GPR_SIZE-1:0]     val_a;
    logic [`GPR_SIZE-1:0]     val_b;
    logic [`ROB_IDX_SIZE-1:0] dst;
    logic                     set_nzcv;
    nzcv_t                    nzcv;
  } issue_t;

  // what leaves the cluster toward the rob
  typedef struct packed {
    logic [`ROB_IDX_SIZE-1:0] dst;
    logic [`GPR_SIZE-1:0]     value;
    nzcv_t                    nzcv;
  } result_t;

endpackage

/* verilog/issue_settings.svh */
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// width of one general purpose register value
`define GPR_SIZE 32

// tag width into the reorder buffer
`define ROB_IDX_SIZE 4

// reservation station depth and the index that addresses it
`define RS_SIZE 4
`define RS_IDX_SIZE 2

`endif

/* verilog/rs_alloc.sv */
`timescale 1ns/10ps
`include "issue_settings.svh"

module rs_alloc (
  input  logic                in_clk,
  input  logic                in_rst,
  input  logic                dispatch_valid,
  input  logic [`RS_SIZE-1:0] busy,
  output logic [`RS_SIZE-1:0] write,
  output logic                full
);

  // one-hot marker of the lowest free entry
  // stays zero when every entry is taken
  logic [`RS_SIZE-1:0] free_pick;

  // priority encoder over the free entries
  // scanning downward so the lowest free index is written last
  always_comb begin
    free_pick = '0;
    for (int i = `RS_SIZE - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_pick    = '0;
        free_pick[i] = 1'b1;
      end
    end
  end

  // steer the dispatch strobe into the picked entry
  // a full station leaves free_pick empty so the dispatch is dropped
  assign write = dispatch_valid ? free_pick : '0;

  // station is full once every entry holds an instruction
  assign full = &busy;

  // at most one entry may take a dispatch per cycle
  a_write_onehot : assert property (
    @(posedge in_clk) disable iff (in_rst)
    $onehot0(write)
  );

endmodule

/* verilog/rs_entry.sv */
`timescale 1ns/10ps
`include "issue_settings.svh"

module rs_entry import issue_pkg::*; (
  input  logic      in_clk,
  input  logic      in_rst,
  input  logic      write,
  input  dispatch_t dispatch,
  input  bcast_t    bcast,
  input  logic      flush,
  input  logic      grant,
  output logic      busy,
  output logic      ready,
  output issue_t    contents
);

  // stored instruction
  alu_op_e                  op;
  operand_t                 op_a;
  operand_t                 op_b;
  logic [`ROB_IDX_SIZE-1:0] dst;
  logic                     set_nzcv;
  nzcv_t                    nzcv;

  // capture a broadcast value when a pending operand's tag matches
  function automatic operand_t snoop(input operand_t src, input bcast_t bc);
    operand_t res;
    res = src;
    if (!src.valid && bc.valid && (bc.rob_index == src.rob_index)) begin
      res.valid = 1'b1;
      res.value = bc.value;
    end
    return res;
  endfunction

  // occupancy
  // flush empties the entry and also drops a dispatch at the same edge
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      busy <= 1'b0;
    end else if (flush) begin
      busy <= 1'b0;
    end else if (write) begin
      busy <= 1'b1;
    end else if (grant) begin
      // entry moves into the issue register at this edge
      busy <= 1'b0;
    end
  end

  // payload and wakeup
  always_ff @(posedge in_clk) begin
    if (write) begin
      op       <= dispatch.op;
      // same-edge broadcast is caught on the way in
      op_a     <= snoop(dispatch.a, bcast);
      op_b     <= snoop(dispatch.b, bcast);
      dst      <= dispatch.dst;
      set_nzcv <= dispatch.set_nzcv;
      nzcv     <= dispatch.nzcv;
    end else if (busy) begin
      op_a <= snoop(op_a, bcast);
      op_b <= snoop(op_b, bcast);
    end
  end

  // both sources resolved
  assign ready = busy & op_a.valid & op_b.valid;

  assign contents.op       = op;
  assign contents.val_a    = op_a.value;
  assign contents.val_b    = op_b.value;
  assign contents.dst      = dst;
  assign contents.set_nzcv = set_nzcv;
  assign contents.nzcv     = nzcv;

  // allocator never overwrites an occupied entry
  a_no_overwrite : assert property (
    @(posedge in_clk) disable iff (in_rst)
    !(write && busy)
  );

endmodule

/* verilog/rs_select.sv */
`timescale 1ns/10ps
`include "issue_settings.svh"

module rs_select import issue_pkg::*; (
  input  logic                in_clk,
  input  logic                in_rst,
  input  logic [`RS_SIZE-1:0] ready,
  input  issue_t              entries [`RS_SIZE],
  input  logic                fu_ready,
  input  logic                flush,
  output logic [`RS_SIZE-1:0] grant,
  output issue_t              issue,
  output logic                issue_valid
);

  // index of the lowest ready entry
  logic [`RS_IDX_SIZE-1:0] sel_idx;
  // a grant goes out this cycle
  logic                    take;

  always_comb begin
    sel_idx = '0;
    for (int i = `RS_SIZE - 1; i >= 0; i--) begin
      if (ready[i]) begin
        sel_idx = `RS_IDX_SIZE'(i);
      end
    end
  end

  // no grant while the alu is stalled or the window is being flushed
  assign take = fu_ready && !flush && (|ready);

  always_comb begin
    grant          = '0;
    grant[sel_idx] = take;
  end

  // issue valid follows the grant whenever the alu drains the register
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      issue_valid <= 1'b0;
    end else if (flush) begin
      issue_valid <= 1'b0;
    end else if (fu_ready) begin
      issue_valid <= take;
    end
  end

  // issue payload loads only on a grant and holds otherwise
  always_ff @(posedge in_clk) begin
    if (take) begin
      issue <= entries[sel_idx];
    end
  end

  // single grant and only to a ready entry
  a_grant_legal : assert property (
    @(posedge in_clk) disable iff (in_rst)
    $onehot0(grant) && ((grant & ~ready) == '0)
  );

endmodule
